// File: logic/ulaPkg.sv
package ulaPkg;

   ////////////////////////////////////////
   // Raster geometry
   ////////////////////////////////////////

   // Pixel clocks per line and lines per frame
   localparam logic [8:0] lineClocks = 9'd448;
   localparam logic [8:0] frameLines = 9'd312;

   // Paper fetch window, in pixel clocks and lines
   localparam logic [8:0] paperFirstCol = 9'd8;
   localparam logic [8:0] paperLastCol  = 9'd263;
   localparam logic [8:0] paperLastLine = 9'd191;

   // Frame interrupt position and width
   localparam logic [8:0] intLine  = 9'd248;
   localparam logic [8:0] intWidth = 9'd64;

   // Composite sync bounds
   localparam logic [8:0] hSyncFirst = 9'd344;
   localparam logic [8:0] hSyncLast  = 9'd375;
   localparam logic [8:0] vSyncFirst = 9'd248;
   localparam logic [8:0] vSyncLast  = 9'd251;

   ////////////////////////////////////////
   // CPU port map
   ////////////////////////////////////////

   // Palette index and palette data ports
   localparam logic [15:0] ulaPortAddr = 16'hBF3B;
   localparam logic [15:0] ulaDataAddr = 16'hFF3B;

   // One colour, GGGRRRBBB
   typedef struct packed {
      logic [2:0] g;
      logic [2:0] r;
      logic [2:0] b;
   } rgb9_t;

   // Result of a colour path
   typedef struct packed {
      rgb9_t ink;
      rgb9_t paper;
   } colourPair_t;

   // Z80 I/O strobes, all active low
   typedef struct packed {
      logic [15:0] addr;
      logic        iorqN;
      logic        rdN;
      logic        wrN;
      logic [7:0]  dataIn;
   } cpuBus_t;

   // Fetched bytes and load strobes
   typedef struct packed {
      logic [7:0] bitmap;
      logic [7:0] attr;
      logic       attrLoad;
      logic       shiftLoad;
      logic       paperArea;
   } fetch_t;

   // Palette RAM write
   typedef struct packed {
      logic       strobe;
      logic [5:0] index;
      logic [7:0] data;
   } paletteWrite_t;

   // Attribute to show next, border is black ink on border paper
   function automatic logic [7:0] shownAttr(input fetch_t f, input logic [2:0] border);
      shownAttr = f.paperArea ? f.attr : {2'b00, border, 3'b000};
   endfunction

endpackage

// File: logic/rasterTiming.sv
`timescale 1ns/1ps

module rasterTiming #(
   parameter int flashRateLog2 = 5
) (
   input  logic       clk7,
   input  logic       rst_n,
   output logic [8:0] hc,
   output logic [8:0] vc,
   output logic       intN,
   output logic       csync,
   output logic       flashPhase
);
   import ulaPkg::*;

   logic                     lineEnd;
   logic                     frameEnd;
   logic [flashRateLog2-1:0] frameCount;

   assign lineEnd  = (hc == lineClocks - 9'd1);
   assign frameEnd = (vc == frameLines - 9'd1);

   // Pixel and line counters
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         hc <= '0;
         vc <= '0;
      end else begin
         hc <= lineEnd ? 9'd0 : hc + 9'd1;
         // line steps on the hc wrap only
         if (lineEnd) begin
            vc <= frameEnd ? 9'd0 : vc + 9'd1;
         end
      end
   end

   // Interrupt is the first 64 clocks of line 248
   assign intN = !(vc == intLine && hc < intWidth);

   // Sync low in either blanking band
   assign csync = !((hc >= hSyncFirst && hc <= hSyncLast) ||
                    (vc >= vSyncFirst && vc <= vSyncLast));

   // Frame count, stepped as the interrupt starts
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         frameCount <= '0;
      end else if (vc == intLine && hc == 9'd0) begin
         frameCount <= frameCount + flashRateLog2'(1);
      end
   end

   assign flashPhase = frameCount[flashRateLog2-1];

endmodule

// File: logic/fetchSequencer.sv
`timescale 1ns/1ps

module fetchSequencer (
   input  logic           clk7,
   input  logic           rst_n,
   input  logic [8:0]     hc,
   input  logic [8:0]     vc,
   input  logic [7:0]     vramData,
   output logic [12:0]    vramAddr,
   output ulaPkg::fetch_t fetch
);
   import ulaPkg::*;

   logic        paperArea;
   logic        bitmapPhase;
   logic        attrPhase;
   logic        attrLoad;
   logic [4:0]  column;
   logic [7:0]  bitmapByte;
   logic [7:0]  attrByte;
   logic [12:0] bitmapAddr;
   logic [12:0] attrAddr;

   ////////////////////////////////////////
   // Window and phase decode
   ////////////////////////////////////////

   // Paper area, shifted 8 clocks ahead of the display
   assign paperArea = (hc >= paperFirstCol) && (hc <= paperLastCol) &&
                      (vc <= paperLastLine);

   // Bitmap on 8, 9, 12, 13
   assign bitmapPhase = paperArea && hc[3] && !hc[1];
   // Attribute on 10, 11, 14, 15
   assign attrPhase   = paperArea && hc[3] && hc[1];

   // Once every 8 clocks
   assign attrLoad = (hc[2:0] == 3'd4);

   // Column of the next byte pair
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         column <= '0;
      end else if (hc[2:0] == 3'd3) begin
         column <= hc[7:3];
      end
   end

   ////////////////////////////////////////
   // VRAM addressing
   ////////////////////////////////////////

   // Interleaved thirds, then pixel row, then character row
   assign bitmapAddr = {vc[7:6], vc[2:0], vc[5:3], column};
   // Attribute block starts at 0x1800
   assign attrAddr   = {3'b110, vc[7:3], column};

   assign vramAddr = attrPhase ? attrAddr : bitmapAddr;

   // Data for the address of the first phase arrives in the second
   always_ff @(posedge clk7) begin
      if (bitmapPhase && hc[0]) begin
         bitmapByte <= vramData;
      end
      if (attrPhase && hc[0]) begin
         attrByte <= vramData;
      end
   end

   // To the shifter and both colour paths
   assign fetch.bitmap    = bitmapByte;
   assign fetch.attr      = attrByte;
   assign fetch.attrLoad  = attrLoad;
   assign fetch.shiftLoad = attrLoad && paperArea;
   assign fetch.paperArea = paperArea;

endmodule

// File: logic/stdAttrColour.sv
`timescale 1ns/1ps

module stdAttrColour (
   input  logic                clk7,
   input  logic                rst_n,
   input  ulaPkg::fetch_t      fetch,
   input  logic [2:0]          border,
   output ulaPkg::colourPair_t stdColours,
   output logic                flashAttr
);
   import ulaPkg::*;

   // DAC levels
   localparam logic [2:0] levelNone = 3'd0;
   localparam logic [2:0] levelHalf = 3'd5;
   localparam logic [2:0] levelFull = 3'd7;

   logic [7:0] attrReg;
   logic       bright;

   // IGRB to GGGRRRBBB
   function automatic rgb9_t igrbColour(input logic hi, input logic [2:0] grb);
      logic [2:0] level;
      level = hi ? levelFull : levelHalf;
      igrbColour.g = grb[2] ? level : levelNone;
      igrbColour.r = grb[1] ? level : levelNone;
      igrbColour.b = grb[0] ? level : levelNone;
   endfunction

   // Attribute for the next 8 pixels
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         attrReg <= '0;
      end else if (fetch.attrLoad) begin
         attrReg <= shownAttr(fetch, border);
      end
   end

   assign bright    = attrReg[6];
   assign flashAttr = attrReg[7];

   // Black stays black even when bright
   assign stdColours.ink   = igrbColour(bright, attrReg[2:0]);
   assign stdColours.paper = igrbColour(bright, attrReg[5:3]);

endmodule

// File: logic/plusPalette.sv
`timescale 1ns/1ps

module plusPalette (
   input  logic                  clk7,
   input  logic                  rst_n,
   input  ulaPkg::fetch_t        fetch,
   input  logic [2:0]            border,
   input  ulaPkg::paletteWrite_t palWrite,
   input  logic [5:0]            readIndex,
   output logic [7:0]            readData,
   output ulaPkg::colourPair_t   plusColours
);
   import ulaPkg::*;

   // 64 entries in GGGRRRBB
   logic [7:0] palRam [64];

   logic [7:0] attr;
   logic [5:0] inkIndex;
   logic [5:0] paperIndex;
   logic [7:0] inkEntry;
   logic [7:0] paperEntry;

   ////////////////////////////////////////
   // CPU side
   ////////////////////////////////////////

   always_ff @(posedge clk7) begin
      if (palWrite.strobe) begin
         palRam[palWrite.index] <= palWrite.data;
      end
      // Readback, one cycle behind the index
      readData <= palRam[readIndex];
   end

   ////////////////////////////////////////
   // Display side
   ////////////////////////////////////////

   assign attr = shownAttr(fetch, border);

   // Flash and bright pick one of four 16-entry groups
   assign inkIndex   = {attr[7:6], 1'b0, attr[2:0]};
   // Paper half of the group, border lands on 8..15
   assign paperIndex = {attr[7:6], 1'b1, attr[5:3]};

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         inkEntry   <= '0;
         paperEntry <= '0;
      end else if (fetch.attrLoad) begin
         inkEntry   <= palRam[inkIndex];
         paperEntry <= palRam[paperIndex];
      end
   end

   // Blue gets B1 repeated as its low bit
   assign plusColours.ink   = rgb9_t'({inkEntry, inkEntry[1]});
   assign plusColours.paper = rgb9_t'({paperEntry, paperEntry[1]});

endmodule

// File: logic/pixelOutput.sv
`timescale 1ns/1ps

module pixelOutput (
   input  logic                clk7,
   input  logic                rst_n,
   input  ulaPkg::fetch_t      fetch,
   input  logic                flashPhase,
   input  logic                flashAttr,
   input  logic                plusEnable,
   input  ulaPkg::colourPair_t stdColours,
   input  ulaPkg::colourPair_t plusColours,
   output logic [2:0]          r,
   output logic [2:0]          g,
   output logic [2:0]          b
);
   import ulaPkg::*;

   logic [7:0] shifter;
   logic       pixelBit;
   logic       stdBit;
   rgb9_t      shown;

   // MSB first, zeros fill in so the border reads as paper
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         shifter <= '0;
      end else if (fetch.shiftLoad) begin
         shifter <= fetch.bitmap;
      end else begin
         shifter <= {shifter[6:0], 1'b0};
      end
   end

   assign pixelBit = shifter[7];

   // Flash swaps ink and paper
   assign stdBit = pixelBit ^ (flashAttr & flashPhase);

   // Final colour select
   always_comb begin
      if (plusEnable) begin
         shown = pixelBit ? plusColours.ink : plusColours.paper;
      end else begin
         shown = stdBit ? stdColours.ink : stdColours.paper;
      end
   end

   assign r = shown.r;
   assign g = shown.g;
   assign b = shown.b;

endmodule

// File: logic/cpuPorts.sv
`timescale 1ns/1ps

module cpuPorts (
   input  logic                  clk7,
   input  logic                  rst_n,
   input  ulaPkg::cpuBus_t       bus,
   input  logic                  ear,
   input  logic [4:0]            kbd,
   input  logic [7:0]            palReadData,
   output logic [7:0]            dout,
   output logic                  mic,
   output logic                  spk,
   output logic [2:0]            border,
   output ulaPkg::paletteWrite_t palWrite,
   output logic [5:0]            readIndex,
   output logic                  plusEnable
);
   import ulaPkg::*;

   logic       ioWrite;
   logic       ioRead;
   logic       selFe;
   logic       selIndex;
   logic       selData;
   logic [6:0] indexReg;

   ////////////////////////////////////////
   // Decode
   ////////////////////////////////////////

   assign ioWrite = !bus.iorqN && !bus.wrN;
   assign ioRead  = !bus.iorqN && !bus.rdN;

   // Any even address is port FE
   assign selFe    = !bus.addr[0];
   assign selIndex = (bus.addr == ulaPortAddr);
   assign selData  = (bus.addr == ulaDataAddr);

   // Port registers
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         border     <= 3'd2;
         mic        <= 1'b0;
         spk        <= 1'b0;
         indexReg   <= '0;
         plusEnable <= 1'b0;
      end else if (ioWrite) begin
         if (selFe) begin
            border <= bus.dataIn[2:0];
            mic    <= bus.dataIn[3];
            spk    <= bus.dataIn[4];
         end
         if (selIndex) begin
            indexReg <= bus.dataIn[6:0];
         end
         // Index bit 6 redirects data writes to the mode register
         if (selData && indexReg[6]) begin
            plusEnable <= bus.dataIn[0];
         end
      end
   end

   // Palette entry write, taken by the RAM on this edge
   assign palWrite.strobe = ioWrite && selData && !indexReg[6];
   assign palWrite.index  = indexReg[5:0];
   assign palWrite.data   = bus.dataIn;

   assign readIndex = indexReg[5:0];

   ////////////////////////////////////////
   // Read mux
   ////////////////////////////////////////

   always_comb begin
      dout = 8'hFF;
      if (ioRead) begin
         if (selFe) begin
            dout = {1'b1, ear, 1'b1, kbd};
         end else if (selIndex) begin
            dout = {1'b0, indexReg};
         end else if (selData) begin
            // mode bit or palette entry
            dout = indexReg[6] ? {7'd0, plusEnable} : palReadData;
         end
      end
   end

endmodule

// File: logic/ulaTop.sv
`timescale 1ns/1ps

module ulaTop #(
   parameter int flashRateLog2 = 5
) (
   input  logic             clk7,
   input  logic             rst_n,
   input  ulaPkg::cpuBus_t  bus,
   input  logic             ear,
   input  logic [4:0]       kbd,
   input  logic [7:0]       vramData,
   output logic [7:0]       dout,
   output logic [12:0]      vramAddr,
   output logic             intN,
   output logic             csync,
   output logic             mic,
   output logic             spk,
   output logic [2:0]       r,
   output logic [2:0]       g,
   output logic [2:0]       b
);
   import ulaPkg::*;

   // Raster position
   logic [8:0] hc;
   logic [8:0] vc;
   logic       flashPhase;

   // Fetch results
   fetch_t fetch;

   // CPU side
   logic [2:0]    border;
   paletteWrite_t palWrite;
   logic [5:0]    readIndex;
   logic [7:0]    palReadData;
   logic          plusEnable;

   // Both colour paths
   colourPair_t stdColours;
   colourPair_t plusColours;
   logic        flashAttr;

   rasterTiming #(
      .flashRateLog2(flashRateLog2)
   ) iRaster (
      .clk7      (clk7),
      .rst_n     (rst_n),
      .hc        (hc),
      .vc        (vc),
      .intN      (intN),
      .csync     (csync),
      .flashPhase(flashPhase)
   );

   fetchSequencer iFetch (
      .clk7    (clk7),
      .rst_n   (rst_n),
      .hc      (hc),
      .vc      (vc),
      .vramData(vramData),
      .vramAddr(vramAddr),
      .fetch   (fetch)
   );

   cpuPorts iPorts (
      .clk7       (clk7),
      .rst_n      (rst_n),
      .bus        (bus),
      .ear        (ear),
      .kbd        (kbd),
      .palReadData(palReadData),
      .dout       (dout),
      .mic        (mic),
      .spk        (spk),
      .border     (border),
      .palWrite   (palWrite),
      .readIndex  (readIndex),
      .plusEnable (plusEnable)
   );

   stdAttrColour iStd (
      .clk7      (clk7),
      .rst_n     (rst_n),
      .fetch     (fetch),
      .border    (border),
      .stdColours(stdColours),
      .flashAttr (flashAttr)
   );

   plusPalette iPlus (
      .clk7       (clk7),
      .rst_n      (rst_n),
      .fetch      (fetch),
      .border     (border),
      .palWrite   (palWrite),
      .readIndex  (readIndex),
      .readData   (palReadData),
      .plusColours(plusColours)
   );

   pixelOutput iPixel (
      .clk7       (clk7),
      .rst_n      (rst_n),
      .fetch      (fetch),
      .flashPhase (flashPhase),
      .flashAttr  (flashAttr),
      .plusEnable (plusEnable),
      .stdColours (stdColours),
      .plusColours(plusColours),
      .r          (r),
      .g          (g),
      .b          (b)
   );

endmodule

// File: verif/tbTasks.svh
////////////////////////////////////////
// Helpers
////////////////////////////////////////

function automatic logic [31:0] lcgNext(input logic [31:0] state);
   lcgNext = state * 32'd1664525 + 32'd1013904223;
endfunction

task automatic checkValue(input string testName, input int expected, input int actual);
   if (expected != actual) begin
      $display("Error in %s: expected 0x%0h, actual 0x%0h", testName, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "Stopped at the first mismatch");
   end
endtask

// One I/O write, strobes low for a single cycle
task automatic ioWrite(input logic [15:0] addr, input logic [7:0] data);
   @(posedge clk7);
   bus.addr   <= addr;
   bus.dataIn <= data;
   bus.iorqN  <= 1'b0;
   bus.wrN    <= 1'b0;
   @(posedge clk7);
   bus.iorqN  <= 1'b1;
   bus.wrN    <= 1'b1;
endtask

// Read data sampled mid cycle
task automatic ioRead(input logic [15:0] addr, output logic [7:0] data);
   @(posedge clk7);
   bus.addr  <= addr;
   bus.iorqN <= 1'b0;
   bus.rdN   <= 1'b0;
   @(negedge clk7);
   data = dout;
   @(posedge clk7);
   bus.iorqN <= 1'b1;
   bus.rdN   <= 1'b1;
endtask

// Stops on the falling edge where the DUT sits at (h, v)
task automatic waitPos(input int h, input int v);
   @(negedge clk7);
   while (!(synced && posH == h && posV == v)) begin
      @(negedge clk7);
   end
endtask

// IGRB to packed GGGRRRBBB
function automatic int stdColour(input logic bright, input logic [2:0] grb);
   int level;
   level = bright ? full : half;
   return (grb[2] ? level : none) * 64 + (grb[1] ? level : none) * 8 + (grb[0] ? level : none);
endfunction

// GGGRRRBB entry, B1 repeated as blue LSB
function automatic int plusColour(input logic [7:0] entry);
   return int'(entry[7:5]) * 64 + int'(entry[4:2]) * 8 + int'(entry[1:0]) * 2 + int'(entry[1]);
endfunction

function automatic int shownColour();
   return int'({pixG, pixR, pixB});
endfunction

// Thirds, pixel row, character row, column
function automatic logic [12:0] bitmapAddress(input int y, input int x);
   return 13'(((y / 64) % 4) * 2048 + (y % 8) * 256 + ((y / 8) % 8) * 32 + x / 8);
endfunction

function automatic logic [12:0] attrAddress(input int y, input int x);
   return 13'(6144 + (y / 8) * 32 + x / 8);
endfunction

// Leftmost pixel is the byte MSB
function automatic logic modelPixel(input int y, input int x);
   logic [7:0] bits;
   bits = vram[bitmapAddress(y, x)] >> (7 - x % 8);
   return bits[0];
endfunction

////////////////////////////////////////
// Directed tests
////////////////////////////////////////

task automatic resetAndBorder();
   logic [7:0] data;
   @(negedge clk7);
   checkValue("reset intN", 1, int'(intN));
   checkValue("reset mic", 0, int'(mic));
   checkValue("reset spk", 0, int'(spk));
   ioRead(ulaPortAddr, data);
   checkValue("reset palette index", 0, int'(data));
   // Enable bit sits behind index 0x40
   ioWrite(ulaPortAddr, 8'h40);
   ioRead(ulaDataAddr, data);
   checkValue("reset palette enable", 0, int'(data));
   ioWrite(ulaPortAddr, 8'h00);
   // Bottom border, red after reset
   waitPos(100, 260);
   checkValue("reset border", stdColour(1'b0, 3'b010), shownColour());
   // Cyan border, mic set
   ioWrite(16'h00FE, 8'h0D);
   @(negedge clk7);
   checkValue("port FE mic", 1, int'(mic));
   checkValue("port FE spk", 0, int'(spk));
   waitPos(100, 270);
   checkValue("cyan border", stdColour(1'b0, 3'b101), shownColour());
   // spk on bit 4 this time
   ioWrite(16'h00FE, 8'h15);
   @(negedge clk7);
   checkValue("port FE mic", 0, int'(mic));
   checkValue("port FE spk", 1, int'(spk));
endtask

task automatic portReads();
   logic [7:0] data;
   for (int i = 0; i < 4; i++) begin
      randState = lcgNext(randState);
      @(posedge clk7);
      ear <= randState[20];
      kbd <= randState[12:8];
      ioRead(16'h7FFE, data);
      checkValue("port FE read", int'({1'b1, randState[20], 1'b1, randState[12:8]}), int'(data));
   end
   // Odd address, no port behind it
   ioRead(16'h00FF, data);
   checkValue("unused port read", 255, int'(data));
endtask

task automatic paperPixels();
   int         lines [4] = '{5, 66, 130, 180};
   int         cols [4] = '{0, 7, 100, 255};
   logic [7:0] attr;
   // No flash in the attribute area
   for (int i = 6144; i < 6912; i++) begin
      vram[13'(i)][7] = 1'b0;
   end
   for (int l = 0; l < 4; l++) begin
      for (int c = 0; c < 4; c++) begin
         waitPos(cols[c] + 13, lines[l]);
         attr = vram[attrAddress(lines[l], cols[c])];
         checkValue("paper pixel", modelPixel(lines[l], cols[c]) ?
                    stdColour(attr[6], attr[2:0]) : stdColour(attr[6], attr[5:3]), shownColour());
      end
   end
endtask

task automatic flashSwap();
   int  colourA;
   int  colourB;
   int  phaseA;
   int  phaseB;
   // Line 191 column 5, cyan ink on red paper with flash
   vram[bitmapAddress(191, 40)] = 8'hF0;
   vram[attrAddress(191, 40)]   = 8'h95;
   waitPos(54, 191);
   // Flash phase is bit 1 of the interrupt count
   phaseA  = (intCount / 2) % 2;
   colourA = shownColour();
   checkValue("flash first frame", (int'(modelPixel(191, 41)) ^ phaseA) != 0 ?
              stdColour(1'b0, 3'b101) : stdColour(1'b0, 3'b010), colourA);
   // Same pixel two frames on
   waitPos(54, 191);
   waitPos(54, 191);
   phaseB  = (intCount / 2) % 2;
   colourB = shownColour();
   checkValue("flash later frame", (int'(modelPixel(191, 41)) ^ phaseB) != 0 ?
              stdColour(1'b0, 3'b101) : stdColour(1'b0, 3'b010), colourB);
endtask

task automatic paletteMode();
   int         lines [2] = '{20, 100};
   int         cols [3] = '{3, 77, 200};
   logic [7:0] data;
   logic [7:0] attr;
   logic [5:0] index;
   for (int i = 0; i < 64; i++) begin
      randState = lcgNext(randState);
      palModel[6'(i)] = randState[23:16];
      ioWrite(ulaPortAddr, 8'(i));
      ioWrite(ulaDataAddr, randState[23:16]);
   end
   for (int i = 0; i < 64; i++) begin
      ioWrite(ulaPortAddr, 8'(i));
      ioRead(ulaDataAddr, data);
      checkValue("palette readback", int'(palModel[6'(i)]), int'(data));
   end
   ioWrite(ulaPortAddr, 8'h40);
   ioWrite(ulaDataAddr, 8'h01);
   ioRead(ulaDataAddr, data);
   checkValue("palette enable", 1, int'(data));
   for (int l = 0; l < 2; l++) begin
      for (int c = 0; c < 3; c++) begin
         waitPos(cols[c] + 13, lines[l]);
         attr = vram[attrAddress(lines[l], cols[c])];
         // Flash and bright pick the group, then ink or paper half
         index = modelPixel(lines[l], cols[c]) ? {attr[7:6], 1'b0, attr[2:0]} :
                 {attr[7:6], 1'b1, attr[5:3]};
         checkValue("palette pixel", plusColour(palModel[index]), shownColour());
      end
   end
   // Border 5 uses paper entry 13
   waitPos(50, 200);
   checkValue("palette border", plusColour(palModel[6'd13]), shownColour());
endtask

task automatic frameTiming();
   int period;
   int lowCycles;
   int syncLow;
   @(negedge clk7);
   while (intN == 1'b0) @(negedge clk7);
   while (intN == 1'b1) @(negedge clk7);
   period    = 0;
   lowCycles = 0;
   while (intN == 1'b0) begin
      lowCycles++;
      period++;
      @(negedge clk7);
   end
   while (intN == 1'b1) begin
      period++;
      @(negedge clk7);
   end
   checkValue("frame period", frameCycles, period);
   checkValue("interrupt width", 64, lowCycles);
   // Line 260 is below vertical sync
   waitPos(0, 260);
   syncLow = 0;
   for (int i = 0; i < lineLen; i++) begin
      if (csync == 1'b0) begin
         syncLow++;
      end
      @(negedge clk7);
   end
   checkValue("line sync width", 32, syncLow);
endtask

// File: verif/tbUla.sv
`timescale 1ns/1ps

module tbUla;
   import ulaPkg::*;

   // DAC levels of the standard palette
   localparam int none = 0;
   localparam int half = 5;
   localparam int full = 7;

   // Raster size
   localparam int lineLen     = 448;
   localparam int frameLen    = 312;
   localparam int frameCycles = lineLen * frameLen;
   // Under one frame to the first interrupt, then about five frames of tests
   localparam int timeoutCycles = 8 * frameCycles;

   logic        clk7;
   logic        rst_n;
   cpuBus_t     bus;
   logic        ear;
   logic [4:0]  kbd;
   logic [7:0]  vramData;
   logic [7:0]  dout;
   logic [12:0] vramAddr;
   logic        intN;
   logic        csync;
   logic        mic;
   logic        spk;
   logic [2:0]  pixR;
   logic [2:0]  pixG;
   logic [2:0]  pixB;

   // VRAM and palette models
   logic [7:0]  vram [8192];
   logic [7:0]  palModel [64];
   logic [31:0] randState;

   // Raster position as seen at the falling clock edge
   logic synced;
   int   posH;
   int   posV;
   int   intCount;
   int   cycleCount;

   ulaTop #(
      .flashRateLog2(2)
   ) i_dut (
      .clk7    (clk7),
      .rst_n   (rst_n),
      .bus     (bus),
      .ear     (ear),
      .kbd     (kbd),
      .vramData(vramData),
      .dout    (dout),
      .vramAddr(vramAddr),
      .intN    (intN),
      .csync   (csync),
      .mic     (mic),
      .spk     (spk),
      .r       (pixR),
      .g       (pixG),
      .b       (pixB)
   );

   always #10 clk7 = ~clk7;

   // Synchronous VRAM, data one cycle after the address
   always @(posedge clk7) begin
      vramData <= vram[vramAddr];
   end

   ////////////////////////////////////////
   // Raster tracking
   ////////////////////////////////////////

   // First low intN marks hc 0 of line 248
   always @(posedge clk7) begin
      if (!synced) begin
         if (intN === 1'b0) begin
            synced   <= 1'b1;
            posH     <= 1;
            posV     <= 248;
            intCount <= 1;
         end
      end else begin
         // Same edge that steps the flash counter
         if (posH == 0 && posV == 248) begin
            intCount <= intCount + 1;
         end
         if (posH == lineLen - 1) begin
            posH <= 0;
            posV <= (posV == frameLen - 1) ? 0 : posV + 1;
         end else begin
            posH <= posH + 1;
         end
      end
   end

   // Run length guard
   always @(posedge clk7) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= timeoutCycles) begin
         $display("Simulation FAILED");
         $fatal(1, "Timeout: tests still running after %0d cycles", timeoutCycles);
      end
   end

   `include "tbTasks.svh"

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin
      clk7       = 1'b0;
      rst_n      = 1'b0;
      bus        = '{addr: 16'h0000, iorqN: 1'b1, rdN: 1'b1, wrN: 1'b1, dataIn: 8'h00};
      ear        = 1'b0;
      kbd        = 5'd0;
      vramData   = 8'h00;
      synced     = 1'b0;
      posH       = 0;
      posV       = 0;
      intCount   = 0;
      cycleCount = 0;
      randState  = 32'hb3d2;
      // Pseudo random screen contents
      for (int i = 0; i < 8192; i++) begin
         randState = lcgNext(randState);
         vram[13'(i)] = randState[23:16];
      end
      repeat (16) @(posedge clk7);
      rst_n <= 1'b1;

      resetAndBorder();
      portReads();
      paperPixels();
      flashSwap();
      paletteMode();
      frameTiming();

      $display("Simulation PASSED");
      $finish;
   end

endmodule

// File: tb.f
+incdir+verif
logic/ulaPkg.sv
logic/rasterTiming.sv
logic/fetchSequencer.sv
logic/stdAttrColour.sv
logic/plusPalette.sv
logic/pixelOutput.sv
logic/cpuPorts.sv
logic/ulaTop.sv
verif/tbUla.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tbUla -f tb.f -o simUla &&
./obj_dir/simUla || exit 1
